/* hdl/link_pkg.sv */
package link_pkg;

  // ----------------------------------------------------------
  // Word and flit geometry of the narrow link
  // ----------------------------------------------------------

  // Width of one push word as it arrives from the host side
  localparam int WORD_W = 32;

  // Width of one flit on the narrow link
  localparam int FLIT_W = 8;

  // Each push word is cut into this many data flits
  localparam int NUM_DATA_FLITS = WORD_W / FLIT_W;

  // Index of a data flit inside its word, 0 to NUM_DATA_FLITS-1
  localparam int FLIT_ID_W = $clog2(NUM_DATA_FLITS);

  // ----------------------------------------------------------
  // Serialization order
  // ----------------------------------------------------------

  // 1 sends the most significant byte first, 0 the least significant
  localparam bit MSB_FIRST = 1'b1;

endpackage : link_pkg

/* hdl/frame_pkg.sv */
package frame_pkg;

  import link_pkg::*;

  // ----------------------------------------------------------
  // Frame layout on the link
  // ----------------------------------------------------------

  // Two check bytes follow the data flits of every word
  localparam int NUM_CHECK_FLITS = 2;

  // Data flits plus check flits, six for a 32-bit word
  localparam int FRAME_FLITS = NUM_DATA_FLITS + NUM_CHECK_FLITS;

  // Link index counts 0 to FRAME_FLITS-1 across a frame
  localparam int LINK_ID_W = $clog2(FRAME_FLITS);

  // ----------------------------------------------------------
  // Framer phases
  // ----------------------------------------------------------

  // Data flits pass through in PH_DATA, then the two check flits go out
  typedef enum logic [1:0] {
    PH_DATA,
    PH_CHECK_A,
    PH_CHECK_B
  } frame_phase_e;

endpackage : frame_pkg

/* hdl/flit_if.sv */
interface flit_if
  import link_pkg::*;
();

  // Flit handshake, a transfer happens when valid and ready are both high
  logic                 valid;
  logic                 ready;

  // Flit payload and its position inside the push word
  logic [FLIT_W-1:0]    data;
  logic [FLIT_ID_W-1:0] id;

  // High on the final data flit of a word
  logic                 last;

  // Serializer side drives the flit and samples ready
  modport src (
    output valid, data, id, last,
    input  ready
  );

  // Framer side consumes the flit and returns ready
  modport dst (
    input  valid, data, id, last,
    output ready
  );

endinterface : flit_if

/* hdl/flow_serializer.sv */
module flow_serializer
  import link_pkg::*;
#(
  // 1 sends the top byte of push_data first, 0 the bottom byte
  parameter bit msb_first = MSB_FIRST
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              push_valid,
  output logic              push_ready,
  input  logic [WORD_W-1:0] push_data,
  flit_if.src               flits
);

  // ----------------------------------------------------------
  // Flit index
  // ----------------------------------------------------------

  // Position of the flit currently offered downstream
  logic [FLIT_ID_W-1:0] flit_idx;
  // Byte lane of push_data that maps to flit_idx
  logic [FLIT_ID_W-1:0] slice_idx;
  logic                 flit_xfer;

  assign flit_xfer = flits.valid && flits.ready;

  // Advances once per accepted flit and wraps after the final one
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flit_idx <= '0;
    end else if (flit_xfer) begin
      if (flits.last) begin
        flit_idx <= '0;
      end else begin
        flit_idx <= flit_idx + 1'b1;
      end
    end
  end

  // ----------------------------------------------------------
  // Flit select, zero cut-through latency
  // ----------------------------------------------------------

  // Reverse the lane order when the top byte goes first
  assign slice_idx = msb_first ? (FLIT_ID_W'(NUM_DATA_FLITS - 1) - flit_idx) : flit_idx;

  // The push word is held stable, so the slice can be taken straight off it
  assign flits.data  = push_data[slice_idx*FLIT_W +: FLIT_W];
  assign flits.valid = push_valid;
  assign flits.id    = flit_idx;
  assign flits.last  = (flit_idx == FLIT_ID_W'(NUM_DATA_FLITS - 1));

  // The word is consumed only when its final flit moves on
  assign push_ready = flits.ready && flits.valid && flits.last;

endmodule : flow_serializer

/* hdl/fletcher_check.sv */
module fletcher_check
  import link_pkg::*;
(
  input  logic [WORD_W-1:0] push_data,
  output logic [FLIT_W-1:0] check_a,
  output logic [FLIT_W-1:0] check_b
);

  // ----------------------------------------------------------
  // Fletcher-style sums over the bytes in send order
  // ----------------------------------------------------------

  // check_a is the plain byte sum, check_b the sum of running sums,
  // which weights b0 by 4 down to b3 by 1
  // Both sums wrap at the flit width, the same modulo 256 as the check bytes
  logic [FLIT_W-1:0] sum_a;
  logic [FLIT_W-1:0] sum_b;
  logic [FLIT_W-1:0] send_byte;

  always_comb begin
    sum_a     = '0;
    sum_b     = '0;
    send_byte = '0;
    for (int k = 0; k < NUM_DATA_FLITS; k++) begin
      // Pick the byte that goes out as flit k
      if (MSB_FIRST) begin
        send_byte = push_data[(NUM_DATA_FLITS-1-k)*FLIT_W +: FLIT_W];
      end else begin
        send_byte = push_data[k*FLIT_W +: FLIT_W];
      end
      sum_a = sum_a + send_byte;
      sum_b = sum_b + sum_a;
    end
  end

  // The wrapped sums are the two check bytes
  assign check_a = sum_a;
  assign check_b = sum_b;

endmodule : fletcher_check

/* hdl/link_framer.sv */
module link_framer
  import link_pkg::*;
  import frame_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  flit_if.dst                  flits,
  input  logic [FLIT_W-1:0]    check_a,
  input  logic [FLIT_W-1:0]    check_b,
  output logic                 link_valid,
  input  logic                 link_ready,
  output logic [FLIT_W-1:0]    link_data,
  output logic [LINK_ID_W-1:0] link_id,
  output logic                 link_last
);

  // ----------------------------------------------------------
  // Phase state
  // ----------------------------------------------------------

  frame_phase_e phase_q;
  frame_phase_e phase_d;

  // Check bytes held for the two trailing flits
  logic [FLIT_W-1:0] chk_a_q;
  logic [FLIT_W-1:0] chk_b_q;

  // Final data flit of a word leaves on the link this cycle
  logic data_done;

  assign data_done = (phase_q == PH_DATA) && flits.valid && flits.ready && flits.last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= PH_DATA;
    end else begin
      phase_q <= phase_d;
    end
  end

  // The push word is still stable at its last flit, so the
  // checker output is valid here and gets latched once per frame
  always_ff @(posedge clk) begin
    if (data_done) begin
      chk_a_q <= check_a;
      chk_b_q <= check_b;
    end
  end

  // Each check flit waits in place until the link takes it
  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      PH_DATA: begin
        if (data_done) phase_d = PH_CHECK_A;
      end
      PH_CHECK_A: begin
        if (link_ready) phase_d = PH_CHECK_B;
      end
      PH_CHECK_B: begin
        if (link_ready) phase_d = PH_DATA;
      end
      default: phase_d = PH_DATA;
    endcase
  end

  // ----------------------------------------------------------
  // Link output mux
  // ----------------------------------------------------------

  always_comb begin
    // Default is data phase pass-through with zero latency
    link_valid  = flits.valid;
    link_data   = flits.data;
    link_id     = LINK_ID_W'(flits.id);
    link_last   = 1'b0;
    flits.ready = link_ready;
    case (phase_q)
      PH_CHECK_A: begin
        // Serializer is stalled while the check bytes go out
        link_valid  = 1'b1;
        link_data   = chk_a_q;
        link_id     = LINK_ID_W'(NUM_DATA_FLITS);
        flits.ready = 1'b0;
      end
      PH_CHECK_B: begin
        link_valid  = 1'b1;
        link_data   = chk_b_q;
        link_id     = LINK_ID_W'(FRAME_FLITS - 1);
        link_last   = 1'b1;
        flits.ready = 1'b0;
      end
      default: ;  // data phase keeps the defaults
    endcase
  end

endmodule : link_framer

/* hdl/link_tx.sv */
module link_tx
  import link_pkg::*;
  import frame_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,

  // Push side, one 32-bit word per frame
  input  logic                 push_valid,
  output logic                 push_ready,
  input  logic [WORD_W-1:0]    push_data,

  // Narrow link side, six flits per frame
  output logic                 link_valid,
  input  logic                 link_ready,
  output logic [FLIT_W-1:0]    link_data,
  output logic [LINK_ID_W-1:0] link_id,
  output logic                 link_last
);

  // ----------------------------------------------------------
  // Internal channels
  // ----------------------------------------------------------

  // Serialized data flits on their way to the framer
  flit_if flits ();

  // Check bytes of the word currently on the push port
  logic [FLIT_W-1:0] check_a;
  logic [FLIT_W-1:0] check_b;

  // ----------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------

  // Serializer and checker both look at the same held push word
  flow_serializer #(
    .msb_first (MSB_FIRST)
  ) u_serializer (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .flits      (flits.src)
  );

  fletcher_check u_check (
    .push_data (push_data),
    .check_a   (check_a),
    .check_b   (check_b)
  );

  // Framer appends the two check flits after the data flits
  link_framer u_framer (
    .clk        (clk),
    .rst_n      (rst_n),
    .flits      (flits.dst),
    .check_a    (check_a),
    .check_b    (check_b),
    .link_valid (link_valid),
    .link_ready (link_ready),
    .link_data  (link_data),
    .link_id    (link_id),
    .link_last  (link_last)
  );

endmodule : link_tx

/* testbench/link_tx_assertions.sv */
module link_tx_assertions
  import link_pkg::*;
  import frame_pkg::*;
(
  input logic                 clk,
  input logic                 rst_n,
  input frame_phase_e         phase_q,
  input logic                 data_done,
  input logic [FLIT_W-1:0]    check_a,
  input logic                 link_valid,
  input logic                 link_ready,
  input logic [FLIT_W-1:0]    link_data,
  input logic [LINK_ID_W-1:0] link_id,
  input logic                 link_last
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  // A stalled flit keeps its payload and index until the link takes it
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    link_valid && !link_ready |=> link_valid && $stable(link_data) && $stable(link_id))
    else begin
      fail_count++;
      $error("Stalled flit changed before the link took it");
    end

  // link_last marks flit 5 and no other
  a_last: assert property (@(posedge clk) disable iff (!rst_n)
    link_valid |-> (link_last == (link_id == LINK_ID_W'(FRAME_FLITS - 1))))
    else begin
      fail_count++;
      $error("link_last does not match link_id");
    end

  // The push word is taken exactly at the transfer of data flit 3
  a_take: assert property (@(posedge clk) disable iff (!rst_n)
    data_done == (link_valid && link_ready && link_id == LINK_ID_W'(NUM_DATA_FLITS - 1)))
    else begin
      fail_count++;
      $error("Word taken away from the id 3 transfer");
    end

  // Once the word is taken the next flit is check A, carrying the
  // check byte of that word and not another data flit
  a_check: assert property (@(posedge clk) disable iff (!rst_n)
    data_done |=> link_valid && link_id == LINK_ID_W'(NUM_DATA_FLITS) &&
                  link_data == $past(check_a))
    else begin
      fail_count++;
      $error("First check flit does not follow the taken word");
    end

endmodule : link_tx_assertions

/* testbench/link_checker.sv */
module link_checker
  import link_pkg::*;
  import frame_pkg::*;
(
  input logic                 clk,
  input logic                 rst_n,
  input logic                 push_valid,
  input logic                 push_ready,
  input logic                 link_valid,
  input logic                 link_ready,
  input logic [FLIT_W-1:0]    link_data,
  input logic [LINK_ID_W-1:0] link_id,
  input logic                 link_last
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int FLIT_TIMEOUT = 200;
  localparam int IDLE_TIMEOUT = 400;

  int unsigned frames_seen;
  int unsigned error_count;

  // Check bytes from the definition, bytes in send order weighted 4 down to 1
  function automatic logic [2*FLIT_W-1:0] rule_checks(input logic [WORD_W-1:0] word);
    int sum_a;
    int sum_b;
    sum_a = 0;
    sum_b = 0;
    for (int k = 0; k < NUM_DATA_FLITS; k++) begin
      sum_a += int'(word[WORD_W-1-k*FLIT_W -: FLIT_W]);
      sum_b += (NUM_DATA_FLITS - k) * int'(word[WORD_W-1-k*FLIT_W -: FLIT_W]);
    end
    return {sum_a[FLIT_W-1:0], sum_b[FLIT_W-1:0]};
  endfunction

  // Follows one frame flit by flit, sampling at the falling edge
  task automatic check_frame(input logic [WORD_W+2*FLIT_W-1:0] frame);
    logic [WORD_W-1:0] word;
    logic [FLIT_W-1:0] want;
    int                cycles;
    int                errs;
    bit                stalled;
    word    = frame[2*FLIT_W +: WORD_W];
    errs    = 0;
    stalled = 1'b0;
    if (rule_checks(word) != frame[2*FLIT_W-1:0]) begin
      $display("MISMATCH at %0t: pattern check bytes %h for word %h, rule gives %h",
               $time, frame[2*FLIT_W-1:0], word, rule_checks(word));
      errs++;
    end
    for (int i = 0; i < FRAME_FLITS && !stalled; i++) begin
      // Top byte goes first, then check_a and check_b
      if (i < NUM_DATA_FLITS) begin
        want = word[WORD_W-1-i*FLIT_W -: FLIT_W];
      end else begin
        want = frame[(FRAME_FLITS-1-i)*FLIT_W +: FLIT_W];
      end
      cycles = 0;
      while (!(link_valid && link_ready) && cycles < FLIT_TIMEOUT) begin
        if (push_ready) begin
          $display("MISMATCH at %0t: push_ready high without a link transfer", $time);
          errs++;
        end
        @(negedge clk);
        cycles++;
      end
      if (!(link_valid && link_ready)) begin
        $display("Link stalled: flit %0d of frame %0d did not move within %0d cycles",
                 i, frames_seen + 1, FLIT_TIMEOUT);
        stalled = 1'b1;
        errs++;
      end else if (link_data !== want || link_id !== LINK_ID_W'(i) ||
                   link_last !== (i == FRAME_FLITS - 1) ||
                   push_ready !== (i == NUM_DATA_FLITS - 1)) begin
        $display("MISMATCH at %0t: frame %0d flit %0d data %h id %0d last %b push_ready %b",
                 $time, frames_seen + 1, i, link_data, link_id, link_last, push_ready);
        $display("MISMATCH at %0t: expected data %h id %0d", $time, want, i);
        errs++;
      end
      @(negedge clk);
    end
    frames_seen++;
    error_count += errs;
    $display("Frame %0d word %h checked, %0d errors", frames_seen, word, errs);
  endtask

  initial begin
    int cycles;
    frames_seen = 0;
    error_count = 0;
    forever begin
      // With no word pushed the link and push_ready must stay low
      cycles = 0;
      while (tb_link_tx.exp_frames.size() == 0 && cycles < IDLE_TIMEOUT) begin
        if (rst_n && !push_valid && (link_valid || push_ready)) begin
          $display("MISMATCH at %0t: link_valid %b push_ready %b with no push word",
                   $time, link_valid, push_ready);
          error_count++;
        end
        @(negedge clk);
        cycles++;
      end
      if (tb_link_tx.exp_frames.size() != 0) begin
        check_frame(tb_link_tx.exp_frames.pop_front());
      end else begin
        $display("No push word arrived within %0d idle cycles", IDLE_TIMEOUT);
        error_count++;
      end
    end
  end

endmodule : link_checker

/* testbench/tb_link_tx.sv */
module tb_link_tx
  import link_pkg::*;
  import frame_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int PUSH_TIMEOUT  = 200;
  localparam int DRAIN_TIMEOUT = 400;

  logic                 clk;
  logic                 rst_n;
  logic                 push_valid;
  logic                 push_ready;
  logic [WORD_W-1:0]    push_data;
  logic                 link_valid;
  logic                 link_ready;
  logic [FLIT_W-1:0]    link_data;
  logic [LINK_ID_W-1:0] link_id;
  logic                 link_last;

  // Expected frames as {word, check_a, check_b}, drained by the checker
  logic [WORD_W+2*FLIT_W-1:0] exp_frames[$];
  int unsigned                words_sent;
  bit                         aborted;

  link_tx u_link_tx (.*);

  link_checker u_checker (.*);

  // Protocol assertions sit inside the framer so they see its phase
  bind link_framer link_tx_assertions u_asrt (
    .clk        (clk),
    .rst_n      (rst_n),
    .phase_q    (phase_q),
    .data_done  (data_done),
    .check_a    (check_a),
    .link_valid (link_valid),
    .link_ready (link_ready),
    .link_data  (link_data),
    .link_id    (link_id),
    .link_last  (link_last)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Link back-pressure
  // ----------------------------------------------------------

  // 16-bit Fibonacci LFSR with taps 16 14 13 11, one new bit per step
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // Two fresh bits per cycle, the link stalls only when both are 0
  initial begin
    logic [15:0] lfsr;
    logic        first_bit;
    lfsr       = 16'd48;
    link_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      lfsr       = lfsr_step(lfsr);
      first_bit  = lfsr[0];
      lfsr       = lfsr_step(lfsr);
      link_ready = first_bit | lfsr[0];
    end
  end

  // ----------------------------------------------------------
  // Push side
  // ----------------------------------------------------------

  // The word stays on the port until push_ready is seen mid-cycle
  task automatic push_word(input logic [WORD_W-1:0] word);
    int cycles;
    bit taken;
    cycles     = 0;
    taken      = 1'b0;
    push_valid = 1'b1;
    push_data  = word;
    while (!taken && cycles < PUSH_TIMEOUT) begin
      @(negedge clk);
      taken = push_ready;
      @(posedge clk);
      #1;
      cycles++;
    end
    push_valid = 1'b0;
    if (taken) begin
      words_sent++;
    end else begin
      $display("Push word %h was not accepted within %0d cycles", word, PUSH_TIMEOUT);
      aborted = 1'b1;
    end
  endtask

  initial begin
    int                fd;
    int                code;
    int                cycles;
    string             line;
    logic [WORD_W-1:0] word;
    logic [FLIT_W-1:0] exp_a;
    logic [FLIT_W-1:0] exp_b;
    rst_n      = 1'b0;
    push_valid = 1'b0;
    push_data  = '0;
    words_sent = 0;
    aborted    = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // A few quiet cycles let the checker see an idle link after reset
    repeat (4) @(posedge clk);
    #1;
    fd = $fopen("testbench/link_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/link_patterns.txt");
      aborted = 1'b1;
    end
    while (fd != 0 && !aborted && !$feof(fd)) begin
      code = $fgets(line, fd);
      // Lines that open with a slash are comments
      if (code > 1 && line.getc(0) != "/") begin
        code = $sscanf(line, "%h %h %h", word, exp_a, exp_b);
        if (code == 3) begin
          exp_frames.push_back({word, exp_a, exp_b});
          push_word(word);
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    // Let the trailing check flits drain out of the framer
    cycles = 0;
    while (u_checker.frames_seen < words_sent && cycles < DRAIN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (u_checker.frames_seen < words_sent) begin
      $display("Link stalled with %0d of %0d frames delivered", u_checker.frames_seen,
               words_sent);
      aborted = 1'b1;
    end
    $display("Frames pushed %0d, checked %0d, errors %0d, assertion failures %0d",
             words_sent, u_checker.frames_seen, u_checker.error_count,
             u_link_tx.u_framer.u_asrt.fail_count);
    if (aborted || words_sent == 0 || u_checker.error_count != 0 ||
        u_link_tx.u_framer.u_asrt.fail_count != 0) begin
      $display("Simulation FAILED");
    end else begin
      $display("Simulation PASSED");
    end
    $finish;
  end

endmodule : tb_link_tx

/* testbench/link_patterns.txt */
// push_word check_a check_b, all hex, one frame per line
// Check bytes follow the Fletcher rule over the bytes sent top byte first
01020304 0a 14
00000000 00 00
ffffffff fc f6
deadbeef 38 ea
12345678 14 08
80ff0180 00 7f
cafef00d c5 0f
a5a55a5a fe 91
7f000001 80 fd
0badf00d b5 20

/* vlog.f */
hdl/link_pkg.sv
hdl/frame_pkg.sv
hdl/flit_if.sv
hdl/flow_serializer.sv
hdl/fletcher_check.sv
hdl/link_framer.sv
hdl/link_tx.sv
testbench/link_tx_assertions.sv
testbench/link_checker.sv
testbench/tb_link_tx.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_link_tx \
  -f vlog.f -o sim_link_tx > build.log 2>&1 \
  && ./obj_dir/sim_link_tx +verilator+error+limit+100 > sim.log 2>&1
grep -qs "^Simulation PASSED$" sim.log && echo "PASS" \
  || { echo "FAIL, see build.log and sim.log"; exit 1; }
